// File: Makefile
TOP  := tb_exc_subsys
SRCS := $(shell grep -v '^+' vlog.f) verif/tb_exc_model.svh

.PHONY: all run clean

all: run

obj_dir/V$(TOP): vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

clean:
	rm -rf obj_dir

// File: common/exc_pkg.sv
`default_nettype none

package exc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  exc_flags_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [4:0]  cp0_addr_t;
    typedef logic [5:0]  irq_t;

    // Flag bit positions, highest priority first
    localparam int FLAG_INST_ADEL = 0;
    localparam int FLAG_RI        = 1;
    localparam int FLAG_OVERFLOW  = 2;
    localparam int FLAG_SYSCALL   = 3;
    localparam int FLAG_BREAK     = 4;
    localparam int FLAG_ERET      = 5;
    localparam int FLAG_DATA_ADEL = 6;
    localparam int FLAG_DATA_ADES = 7;

    // Cause ExcCode values
    localparam exccode_t EXC_INT  = 5'd0;
    localparam exccode_t EXC_ADEL = 5'd4;
    localparam exccode_t EXC_ADES = 5'd5;
    localparam exccode_t EXC_SYS  = 5'd8;
    localparam exccode_t EXC_BP   = 5'd9;
    localparam exccode_t EXC_RI   = 5'd10;
    localparam exccode_t EXC_OV   = 5'd12;

    // CP0 register numbers
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    localparam word_t EXC_VECTOR = 32'hBFC0_0380;

    // BEV set out of reset
    localparam word_t STATUS_RESET = 32'h0040_0000;

    // IM[15:8], EXL and IE
    localparam word_t STATUS_WMASK = 32'h0000_FF03;
    // software interrupt bits IP[9:8] only
    localparam word_t CAUSE_WMASK  = 32'h0000_0300;

    // Status and Cause field positions
    localparam int STATUS_IE        = 0;
    localparam int STATUS_EXL       = 1;
    localparam int STATUS_IM_LO     = 8;
    localparam int CAUSE_EXCCODE_LO = 2;
    localparam int CAUSE_IP_LO      = 8;
    localparam int CAUSE_HW_IP_LO   = 10;
    localparam int CAUSE_TI         = 30;
    localparam int CAUSE_BD         = 31;

endpackage

`default_nettype wire

// File: exception/cp0_regs.sv
`default_nettype none

module cp0_regs (
    input  wire                     clk,
    input  wire                     arst_n,

    input  wire exc_pkg::irq_t      hw_int,

    // Exception and eret updates
    input  wire                     exc_update,
    input  wire exc_pkg::exccode_t  exc_code,
    input  wire                     exc_bd,
    input  wire exc_pkg::word_t     exc_epc,
    input  wire                     exc_badvaddr_ena,
    input  wire exc_pkg::word_t     exc_badvaddr,
    input  wire                     exl_clear,

    // Move-to / move-from
    input  wire                     cp0_wen,
    input  wire exc_pkg::cp0_addr_t cp0_waddr,
    input  wire exc_pkg::word_t     cp0_wdata,
    input  wire exc_pkg::cp0_addr_t cp0_raddr,
    output exc_pkg::word_t          cp0_rdata,

    output exc_pkg::word_t          epc,
    output logic                    int_pending
);

    exc_pkg::word_t    badvaddr_q;
    exc_pkg::word_t    count_q;
    exc_pkg::word_t    compare_q;
    exc_pkg::word_t    status_q;
    exc_pkg::word_t    status_d;
    exc_pkg::word_t    epc_q;

    // Cause is kept as separate fields
    exc_pkg::word_t    cause_sw_q;
    exc_pkg::exccode_t cause_exccode_q;
    logic              cause_bd_q;
    logic              cause_ti_q;
    exc_pkg::irq_t     ip_hw;
    exc_pkg::word_t    cause_rd;

    logic              wr_badvaddr;
    logic              wr_count;
    logic              wr_compare;
    logic              wr_status;
    logic              wr_cause;
    logic              wr_epc;
    logic              exl;

    assign wr_badvaddr = cp0_wen && (cp0_waddr == exc_pkg::CP0_BADVADDR);
    assign wr_count    = cp0_wen && (cp0_waddr == exc_pkg::CP0_COUNT);
    assign wr_compare  = cp0_wen && (cp0_waddr == exc_pkg::CP0_COMPARE);
    assign wr_status   = cp0_wen && (cp0_waddr == exc_pkg::CP0_STATUS);
    assign wr_cause    = cp0_wen && (cp0_waddr == exc_pkg::CP0_CAUSE);
    assign wr_epc      = cp0_wen && (cp0_waddr == exc_pkg::CP0_EPC);

    assign exl = status_q[exc_pkg::STATUS_EXL];

    // Move-to first, then the exception or eret takes EXL
    always_comb begin
        status_d = status_q;
        if (wr_status) begin
            status_d = (status_q & ~exc_pkg::STATUS_WMASK) |
                       (cp0_wdata & exc_pkg::STATUS_WMASK);
        end
        if (exc_update) begin
            status_d[exc_pkg::STATUS_EXL] = 1'b1;
        end else if (exl_clear) begin
            status_d[exc_pkg::STATUS_EXL] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q        <= exc_pkg::STATUS_RESET;
            cause_sw_q      <= '0;
            cause_exccode_q <= exc_pkg::EXC_INT;
            cause_bd_q      <= 1'b0;
            epc_q           <= '0;
            badvaddr_q      <= '0;
        end else begin
            status_q <= status_d;
            if (wr_cause) begin
                cause_sw_q <= cp0_wdata & exc_pkg::CAUSE_WMASK;
            end
            if (exc_update) begin
                cause_exccode_q <= exc_code;
            end
            // A nested exception keeps the original return point
            if (exc_update && !exl) begin
                cause_bd_q <= exc_bd;
                epc_q      <= exc_epc;
            end else if (wr_epc) begin
                epc_q <= cp0_wdata;
            end
            if (exc_badvaddr_ena) begin
                badvaddr_q <= exc_badvaddr;
            end else if (wr_badvaddr) begin
                badvaddr_q <= cp0_wdata;
            end
        end
    end

    // Count/compare timer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q    <= '0;
            compare_q  <= '0;
            cause_ti_q <= 1'b0;
        end else begin
            count_q <= wr_count ? cp0_wdata : count_q + 32'd1;
            if (wr_compare) begin
                compare_q  <= cp0_wdata;
                cause_ti_q <= 1'b0;
            end else if (count_q == compare_q) begin
                cause_ti_q <= 1'b1;
            end
        end
    end

    // timer shares IP7 with the top hardware line
    assign ip_hw = {hw_int[5] | cause_ti_q, hw_int[4:0]};

    always_comb begin
        cause_rd = cause_sw_q;
        cause_rd[exc_pkg::CAUSE_BD] = cause_bd_q;
        cause_rd[exc_pkg::CAUSE_TI] = cause_ti_q;
        cause_rd[exc_pkg::CAUSE_HW_IP_LO +: 6] = ip_hw;
        cause_rd[exc_pkg::CAUSE_EXCCODE_LO +: 5] = cause_exccode_q;
    end

    assign int_pending = status_q[exc_pkg::STATUS_IE] && !exl &&
                         |(cause_rd[exc_pkg::CAUSE_IP_LO +: 8] &
                           status_q[exc_pkg::STATUS_IM_LO +: 8]);

    assign epc = epc_q;

    always_comb begin
        case (cp0_raddr)
            exc_pkg::CP0_BADVADDR: cp0_rdata = badvaddr_q;
            exc_pkg::CP0_COUNT:    cp0_rdata = count_q;
            exc_pkg::CP0_COMPARE:  cp0_rdata = compare_q;
            exc_pkg::CP0_STATUS:   cp0_rdata = status_q;
            exc_pkg::CP0_CAUSE:    cp0_rdata = cause_rd;
            exc_pkg::CP0_EPC:      cp0_rdata = epc_q;
            default:               cp0_rdata = '0;
        endcase
    end

    // The controller never takes an exception and an eret in one cycle
    update_excl_eret: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(exc_update && exl_clear)
    );

endmodule

`default_nettype wire

// File: exception/exception_ctrl.sv
`default_nettype none

module exception_ctrl (
    // Only used by the assertion
    input  wire                     clk,
    input  wire                     arst_n,

    // Older instruction
    input  wire exc_pkg::word_t     pc_1,
    input  wire                     in_delay_slot_1,
    input  wire exc_pkg::exc_flags_t exc_flags_1,
    input  wire exc_pkg::word_t     mem_addr_1,

    // Younger instruction
    input  wire exc_pkg::word_t     pc_2,
    input  wire                     in_delay_slot_2,
    input  wire exc_pkg::exc_flags_t exc_flags_2,
    input  wire exc_pkg::word_t     mem_addr_2,

    // From CP0
    input  wire                     int_pending,
    input  wire exc_pkg::word_t     epc,

    // PC redirect and flush
    output logic                    redirect_valid,
    output exc_pkg::word_t          redirect_pc,
    output logic                    flush,

    // CP0 update
    output logic                    exc_update,
    output exc_pkg::exccode_t       exc_code,
    output logic                    exc_bd,
    output exc_pkg::word_t          exc_epc,
    output logic                    exc_badvaddr_ena,
    output exc_pkg::word_t          exc_badvaddr,
    output logic                    exl_clear
);

    logic                has_1;
    logic                has_2;
    logic                take_1;
    logic                taken;

    // Fields of the slot that owns the event
    exc_pkg::exc_flags_t sel_flags;
    exc_pkg::word_t      sel_pc;
    exc_pkg::word_t      sel_addr;
    logic                sel_bd;

    assign has_1 = |exc_flags_1;
    assign has_2 = |exc_flags_2;

    // Interrupts are charged to slot 1
    assign take_1 = int_pending | has_1;
    assign taken  = take_1 | has_2;

    assign sel_flags = take_1 ? exc_flags_1     : exc_flags_2;
    assign sel_pc    = take_1 ? pc_1            : pc_2;
    assign sel_addr  = take_1 ? mem_addr_1      : mem_addr_2;
    assign sel_bd    = take_1 ? in_delay_slot_1 : in_delay_slot_2;

    // Restart at the branch when the victim sits in its delay slot
    assign exc_bd  = sel_bd;
    assign exc_epc = sel_bd ? sel_pc - 32'd4 : sel_pc;

    assign redirect_valid = taken;
    assign flush          = taken;

    always_comb begin
        redirect_pc      = exc_pkg::EXC_VECTOR;
        exc_update       = 1'b0;
        exc_code         = exc_pkg::EXC_INT;
        exc_badvaddr_ena = 1'b0;
        exc_badvaddr     = sel_pc;
        exl_clear        = 1'b0;

        if (int_pending) begin
            exc_update = 1'b1;
            exc_code   = exc_pkg::EXC_INT;
        end else if (taken) begin
            exc_update = 1'b1;
            if (sel_flags[exc_pkg::FLAG_INST_ADEL]) begin
                // fetch from a bad PC
                exc_code         = exc_pkg::EXC_ADEL;
                exc_badvaddr_ena = 1'b1;
                exc_badvaddr     = sel_pc;
            end else if (sel_flags[exc_pkg::FLAG_RI]) begin
                exc_code = exc_pkg::EXC_RI;
            end else if (sel_flags[exc_pkg::FLAG_OVERFLOW]) begin
                exc_code = exc_pkg::EXC_OV;
            end else if (sel_flags[exc_pkg::FLAG_SYSCALL]) begin
                exc_code = exc_pkg::EXC_SYS;
            end else if (sel_flags[exc_pkg::FLAG_BREAK]) begin
                exc_code = exc_pkg::EXC_BP;
            end else if (sel_flags[exc_pkg::FLAG_ERET]) begin
                // Return from handler, no CP0 capture
                exc_update  = 1'b0;
                exl_clear   = 1'b1;
                redirect_pc = epc;
            end else if (sel_flags[exc_pkg::FLAG_DATA_ADEL]) begin
                exc_code         = exc_pkg::EXC_ADEL;
                exc_badvaddr_ena = 1'b1;
                exc_badvaddr     = sel_addr;
            end else begin
                exc_code         = exc_pkg::EXC_ADES;
                exc_badvaddr_ena = 1'b1;
                exc_badvaddr     = sel_addr;
            end
        end
    end

    // BadVAddr is only ever written as part of a full exception update
    badvaddr_needs_update: assert property (
        @(posedge clk) disable iff (!arst_n)
        exc_badvaddr_ena |-> exc_update
    );

endmodule

`default_nettype wire

// File: verif/tb_exc_model.svh
// Reference state of the CP0 registers
exc_pkg::word_t    m_status;
exc_pkg::word_t    m_cause_sw;
exc_pkg::word_t    m_epc;
exc_pkg::word_t    m_badvaddr;
exc_pkg::word_t    m_count;
exc_pkg::word_t    m_compare;
exc_pkg::exccode_t m_exccode;
logic              m_bd;
logic              m_ti;

task automatic model_reset();
    m_status   = 32'h0040_0000;
    m_cause_sw = '0;
    m_epc      = '0;
    m_badvaddr = '0;
    m_count    = '0;
    m_compare  = '0;
    m_exccode  = 5'd0;
    m_bd       = 1'b0;
    m_ti       = 1'b0;
endtask

// Cause as software sees it, with IP7 shared by the timer
function automatic exc_pkg::word_t model_cause(input exc_pkg::irq_t hw);
    exc_pkg::word_t c;
    c = m_cause_sw & 32'h0000_0300;
    c[31] = m_bd;
    c[30] = m_ti;
    c[15:10] = {hw[5] | m_ti, hw[4:0]};
    c[6:2] = m_exccode;
    return c;
endfunction

function automatic exc_pkg::word_t model_read(input exc_pkg::cp0_addr_t a,
                                              input exc_pkg::irq_t hw);
    case (a)
        5'd8:    return m_badvaddr;
        5'd9:    return m_count;
        5'd11:   return m_compare;
        5'd12:   return m_status;
        5'd13:   return model_cause(hw);
        5'd14:   return m_epc;
        default: return '0;
    endcase
endfunction

function automatic logic model_int_pending(input exc_pkg::irq_t hw);
    exc_pkg::word_t c;
    c = model_cause(hw);
    return m_status[0] && !m_status[1] && (|(c[15:8] & m_status[15:8]));
endfunction

// Event selection: interrupt, then slot 1, then slot 2, flag order within a slot
task automatic model_predict(
    input  exc_pkg::exc_flags_t f1, input exc_pkg::exc_flags_t f2,
    input  exc_pkg::word_t pc1, input exc_pkg::word_t pc2,
    input  logic ds1, input logic ds2,
    input  exc_pkg::word_t a1, input exc_pkg::word_t a2,
    input  exc_pkg::irq_t hw,
    output logic rv, output exc_pkg::word_t rpc, output logic upd,
    output exc_pkg::exccode_t code, output logic bd, output exc_pkg::word_t epcv,
    output logic bva_en, output exc_pkg::word_t bva, output logic eret);
    logic intp;
    logic s1;
    exc_pkg::exc_flags_t f;
    exc_pkg::word_t pc;
    exc_pkg::word_t a;
    intp = model_int_pending(hw);
    s1 = intp || (f1 != 8'd0);
    rv = s1 || (f2 != 8'd0);
    f = s1 ? f1 : f2;
    pc = s1 ? pc1 : pc2;
    a = s1 ? a1 : a2;
    bd = s1 ? ds1 : ds2;
    epcv = bd ? pc - 32'd4 : pc;
    rpc = 32'hBFC0_0380;
    upd = rv;
    code = 5'd0;
    bva_en = 1'b0;
    bva = '0;
    eret = 1'b0;
    if (intp || !rv) begin
        code = 5'd0;
    end else if (f[exc_pkg::FLAG_INST_ADEL]) begin
        code = 5'd4;
        bva_en = 1'b1;
        bva = pc;
    end else if (f[exc_pkg::FLAG_RI]) begin
        code = 5'd10;
    end else if (f[exc_pkg::FLAG_OVERFLOW]) begin
        code = 5'd12;
    end else if (f[exc_pkg::FLAG_SYSCALL]) begin
        code = 5'd8;
    end else if (f[exc_pkg::FLAG_BREAK]) begin
        code = 5'd9;
    end else if (f[exc_pkg::FLAG_ERET]) begin
        upd = 1'b0;
        eret = 1'b1;
        rpc = m_epc;
    end else begin
        code = f[exc_pkg::FLAG_DATA_ADEL] ? 5'd4 : 5'd5;
        bva_en = 1'b1;
        bva = a;
    end
endtask

// Register state after the next rising edge
task automatic model_update(
    input logic wen, input exc_pkg::cp0_addr_t wa, input exc_pkg::word_t wd,
    input logic upd, input exc_pkg::exccode_t code, input logic bd,
    input exc_pkg::word_t epcv, input logic bva_en, input exc_pkg::word_t bva,
    input logic eret);
    logic exl_old;
    exl_old = m_status[1];
    if (wen && wa == 5'd12) begin
        m_status = (m_status & ~32'h0000_FF03) | (wd & 32'h0000_FF03);
    end
    if (upd) begin
        m_status[1] = 1'b1;
    end else if (eret) begin
        m_status[1] = 1'b0;
    end
    if (wen && wa == 5'd13) begin
        m_cause_sw = wd & 32'h0000_0300;
    end
    if (upd) begin
        m_exccode = code;
    end
    if (upd && !exl_old) begin
        m_bd = bd;
        m_epc = epcv;
    end else if (wen && wa == 5'd14) begin
        m_epc = wd;
    end
    if (bva_en) begin
        m_badvaddr = bva;
    end else if (wen && wa == 5'd8) begin
        m_badvaddr = wd;
    end
    // Match is seen with the old Count
    if (wen && wa == 5'd11) begin
        m_compare = wd;
        m_ti = 1'b0;
    end else if (m_count == m_compare) begin
        m_ti = 1'b1;
    end
    m_count = (wen && wa == 5'd9) ? wd : m_count + 32'd1;
endtask

// File: verif/tb_exc_subsys.sv
`default_nettype none

module tb_exc_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    // Upper bound of all tests together
    localparam int TEST_CYCLES = 3000;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                clk;
    logic                arst_n;
    exc_pkg::word_t      pc_1;
    logic                in_delay_slot_1;
    exc_pkg::exc_flags_t exc_flags_1;
    exc_pkg::word_t      mem_addr_1;
    exc_pkg::word_t      pc_2;
    logic                in_delay_slot_2;
    exc_pkg::exc_flags_t exc_flags_2;
    exc_pkg::word_t      mem_addr_2;
    exc_pkg::irq_t       hw_int;
    logic                cp0_wen;
    exc_pkg::cp0_addr_t  cp0_waddr;
    exc_pkg::word_t      cp0_wdata;
    exc_pkg::cp0_addr_t  cp0_raddr;
    exc_pkg::word_t      cp0_rdata;
    logic                redirect_valid;
    exc_pkg::word_t      redirect_pc;
    logic                flush;

    string test_name;
    int    errors;
    int    checks;
    int    tests;
    int    cycles;

    `include "tb_exc_model.svh"

    exc_subsys_top dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .pc_1            (pc_1),
        .in_delay_slot_1 (in_delay_slot_1),
        .exc_flags_1     (exc_flags_1),
        .mem_addr_1      (mem_addr_1),
        .pc_2            (pc_2),
        .in_delay_slot_2 (in_delay_slot_2),
        .exc_flags_2     (exc_flags_2),
        .mem_addr_2      (mem_addr_2),
        .hw_int          (hw_int),
        .cp0_wen         (cp0_wen),
        .cp0_waddr       (cp0_waddr),
        .cp0_wdata       (cp0_wdata),
        .cp0_raddr       (cp0_raddr),
        .cp0_rdata       (cp0_rdata),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .flush           (flush)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input exc_pkg::word_t exp,
                         input exc_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic exc_pkg::cp0_addr_t reg_at(input int i);
        case (i)
            0:       return 5'd8;
            1:       return 5'd9;
            2:       return 5'd11;
            3:       return 5'd12;
            4:       return 5'd13;
            default: return 5'd14;
        endcase
    endfunction

    task automatic set_idle();
        exc_flags_1 = '0;
        exc_flags_2 = '0;
        in_delay_slot_1 = 1'b0;
        in_delay_slot_2 = 1'b0;
        cp0_wen = 1'b0;
    endtask

    task automatic mtc0(input exc_pkg::cp0_addr_t a, input exc_pkg::word_t d);
        cp0_wen = 1'b1;
        cp0_waddr = a;
        cp0_wdata = d;
    endtask

    // One clock: inputs are already driven at the falling edge
    task automatic cycle();
        logic              rv;
        logic              upd;
        logic              bd;
        logic              bva_en;
        logic              eret;
        exc_pkg::word_t    rpc;
        exc_pkg::word_t    epcv;
        exc_pkg::word_t    bva;
        exc_pkg::exccode_t code;
        model_predict(exc_flags_1, exc_flags_2, pc_1, pc_2, in_delay_slot_1,
                      in_delay_slot_2, mem_addr_1, mem_addr_2, hw_int,
                      rv, rpc, upd, code, bd, epcv, bva_en, bva, eret);
        #1;
        check("redirect_valid", 32'(rv), 32'(redirect_valid));
        check("flush", 32'(rv), 32'(flush));
        if (rv) begin
            check("redirect_pc", rpc, redirect_pc);
        end
        check("cp0_rdata", model_read(cp0_raddr, hw_int), cp0_rdata);
        model_update(cp0_wen, cp0_waddr, cp0_wdata, upd, code, bd, epcv,
                     bva_en, bva, eret);
        @(negedge clk);
        set_idle();
    endtask

    task automatic random_slots();
        pc_1 = $urandom;
        pc_2 = $urandom;
        mem_addr_1 = $urandom;
        mem_addr_2 = $urandom;
        in_delay_slot_1 = 1'($urandom);
        in_delay_slot_2 = 1'($urandom);
    endtask

    task automatic finish_test(input int errs_before);
        tests++;
        $display("%s: done, %0d errors", test_name, errors - errs_before);
    endtask

    initial begin
        int e0;
        int off;
        exc_pkg::word_t sdata;
        clk = 1'b0;
        arst_n = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        pc_1 = '0;
        pc_2 = '0;
        mem_addr_1 = '0;
        mem_addr_2 = '0;
        hw_int = '0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        cp0_raddr = '0;
        set_idle();
        void'($urandom(32'h5bb2));
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        model_reset();

        test_name = "reset";
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            // Cause first, before Count meets Compare and sets TI
            cp0_raddr = reg_at((i + 4) % 6);
            cycle();
        end
        finish_test(e0);

        test_name = "single_slot";
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            // IE stays 0 so the flags decide; EXL sometimes kept set
            sdata = ($urandom & 32'h0000_FF00) | {30'd0, ($urandom % 4 == 0), 1'b0};
            mtc0(5'd12, sdata);
            cp0_raddr = reg_at($urandom_range(5, 0));
            cycle();
            random_slots();
            if ($urandom % 2 == 0) begin
                exc_flags_1 = 8'd1 << $urandom_range(7, 0);
            end else begin
                exc_flags_2 = 8'd1 << $urandom_range(7, 0);
            end
            cp0_raddr = reg_at($urandom_range(5, 0));
            cycle();
        end
        finish_test(e0);

        test_name = "dual_slot";
        e0 = errors;
        mtc0(5'd12, 32'h0);
        cycle();
        for (int i = 0; i < 200; i++) begin
            random_slots();
            exc_flags_1 = 8'($urandom) & 8'($urandom);
            exc_flags_2 = 8'($urandom);
            cp0_raddr = reg_at($urandom_range(5, 0));
            cycle();
        end
        finish_test(e0);

        test_name = "eret";
        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            mtc0(5'd14, $urandom);
            cycle();
            mtc0(5'd12, 32'h0000_0002);
            cp0_raddr = 5'd14;
            cycle();
            random_slots();
            if ($urandom % 2 == 0) begin
                exc_flags_1 = 8'd1 << exc_pkg::FLAG_ERET;
                exc_flags_2 = 8'($urandom);
            end else begin
                exc_flags_2 = 8'd1 << exc_pkg::FLAG_ERET;
            end
            cycle();
            cp0_raddr = 5'd12;
            cycle();
            cp0_raddr = 5'd14;
            cycle();
        end
        finish_test(e0);

        test_name = "interrupt";
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            mtc0(5'd12, $urandom & 32'h0000_FF03);
            cycle();
            if ($urandom % 4 == 0) begin
                mtc0(5'd13, $urandom);
            end
            cycle();
            hw_int = 6'($urandom);
            random_slots();
            exc_flags_1 = 8'($urandom) & 8'($urandom) & 8'($urandom);
            cp0_raddr = 5'd13;
            cycle();
            hw_int = '0;
        end
        // Count/compare timer
        for (int i = 0; i < 12; i++) begin
            off = $urandom_range(30, 2);
            mtc0(5'd12, 32'h0000_8000);
            cycle();
            mtc0(5'd9, $urandom);
            cycle();
            mtc0(5'd11, m_count + 32'(off));
            cycle();
            cp0_raddr = 5'd13;
            repeat (off + 4) cycle();
            mtc0(5'd11, m_count + 32'h8000_0000);
            cycle();
            cycle();
        end
        finish_test(e0);

        test_name = "move_to_from";
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            if ($urandom % 4 != 0) begin
                mtc0(reg_at($urandom_range(5, 0)), $urandom & 32'hFFFF_FFFE);
            end
            cp0_raddr = reg_at($urandom_range(5, 0));
            cycle();
        end
        finish_test(e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/exc_subsys_top.sv
`default_nettype none

module exc_subsys_top (
    input  wire                      clk,
    input  wire                      arst_n,

    input  wire exc_pkg::word_t      pc_1,
    input  wire                      in_delay_slot_1,
    input  wire exc_pkg::exc_flags_t exc_flags_1,
    input  wire exc_pkg::word_t      mem_addr_1,

    input  wire exc_pkg::word_t      pc_2,
    input  wire                      in_delay_slot_2,
    input  wire exc_pkg::exc_flags_t exc_flags_2,
    input  wire exc_pkg::word_t      mem_addr_2,

    input  wire exc_pkg::irq_t       hw_int,

    input  wire                      cp0_wen,
    input  wire exc_pkg::cp0_addr_t  cp0_waddr,
    input  wire exc_pkg::word_t      cp0_wdata,
    input  wire exc_pkg::cp0_addr_t  cp0_raddr,
    output wire exc_pkg::word_t      cp0_rdata,

    output wire                      redirect_valid,
    output wire exc_pkg::word_t      redirect_pc,
    output wire                      flush
);

    wire                    int_pending;
    wire exc_pkg::word_t    epc;
    wire                    exc_update;
    wire exc_pkg::exccode_t exc_code;
    wire                    exc_bd;
    wire exc_pkg::word_t    exc_epc;
    wire                    exc_badvaddr_ena;
    wire exc_pkg::word_t    exc_badvaddr;
    wire                    exl_clear;

    exception_ctrl u_exception_ctrl (
        .clk              (clk),
        .arst_n           (arst_n),
        .pc_1             (pc_1),
        .in_delay_slot_1  (in_delay_slot_1),
        .exc_flags_1      (exc_flags_1),
        .mem_addr_1       (mem_addr_1),
        .pc_2             (pc_2),
        .in_delay_slot_2  (in_delay_slot_2),
        .exc_flags_2      (exc_flags_2),
        .mem_addr_2       (mem_addr_2),
        .int_pending      (int_pending),
        .epc              (epc),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .flush            (flush),
        .exc_update       (exc_update),
        .exc_code         (exc_code),
        .exc_bd           (exc_bd),
        .exc_epc          (exc_epc),
        .exc_badvaddr_ena (exc_badvaddr_ena),
        .exc_badvaddr     (exc_badvaddr),
        .exl_clear        (exl_clear)
    );

    cp0_regs u_cp0_regs (
        .clk              (clk),
        .arst_n           (arst_n),
        .hw_int           (hw_int),
        .exc_update       (exc_update),
        .exc_code         (exc_code),
        .exc_bd           (exc_bd),
        .exc_epc          (exc_epc),
        .exc_badvaddr_ena (exc_badvaddr_ena),
        .exc_badvaddr     (exc_badvaddr),
        .exl_clear        (exl_clear),
        .cp0_wen          (cp0_wen),
        .cp0_waddr        (cp0_waddr),
        .cp0_wdata        (cp0_wdata),
        .cp0_raddr        (cp0_raddr),
        .cp0_rdata        (cp0_rdata),
        .epc              (epc),
        .int_pending      (int_pending)
    );

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verif
common/exc_pkg.sv
exception/exception_ctrl.sv
exception/cp0_regs.sv
verilog/exc_subsys_top.sv
verif/tb_exc_subsys.sv
